// ==== rtl/telem_pkg.sv ====
package telem_pkg;

    // channel count is fixed by the pin-out.
    localparam int NUM_CHAN = 4;

    // one-hot gate word per code channel.
    localparam int GT_W = 3;

    // one-hot data timing word.
    localparam int DT_W = 3;

    // frame phases, in strobe order.
    localparam int PH_V1 = 0;
    localparam int PH_W1 = 1;
    localparam int PH_X8 = 2;
    localparam int PH_Y8 = 3;
    localparam int PH_Z1 = 4;

    localparam int NUM_PH = 5;

    // phase counter width.
    localparam int PH_CNT_W = $clog2(NUM_PH);

    // gcsync must be seen high this many samples in a row.
    localparam int SYNC_FILT_LEN = 3;

endpackage

// ==== rtl/telem_timing_if.sv ====
`timescale 1ns/1ps

interface telem_timing_if;

    logic v1;
    logic w1;
    logic x8;
    logic y8;
    logic z1;

    modport source (
        output v1, w1, x8, y8, z1
    );

    modport sink (
        input v1, w1, x8, y8, z1
    );

endinterface

// ==== rtl/telem_cond_if.sv ====
`timescale 1ns/1ps

interface telem_cond_if;

    logic paav;  // address valid.
    logic resmv; // resume.
    logic codgv;
    logic etcr;
    logic mcft2;
    logic dls;   // channel load.

    modport source (
        output paav, resmv, codgv, etcr, mcft2, dls
    );

    modport sink (
        input paav, resmv, codgv, etcr, mcft2, dls
    );

endinterface

// ==== rtl/telem_pulse_gen.sv ====
`timescale 1ns/1ps

module telem_pulse_gen
    import telem_pkg::*;
(
    input  logic           sim_clk,
    input  logic           reset,
    telem_timing_if.source tim
);

    logic [PH_CNT_W-1:0] ph_cnt;
    logic [NUM_PH-1:0]   ph_dec;
    logic [NUM_PH-1:0]   ph_q;

    // phase about to be issued.
    always_comb begin
        ph_dec = '0;
        ph_dec[ph_cnt] = 1'b1;
    end

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            ph_cnt <= '0;
            ph_q   <= '0; // quiet in reset.
        end else begin
            ph_q <= ph_dec;
            if (ph_cnt == PH_CNT_W'(NUM_PH - 1)) begin
                ph_cnt <= '0;
            end else begin
                ph_cnt <= ph_cnt + 1'b1;
            end
        end
    end

    // one strobe per cycle, v1 first.
    assign tim.v1 = ph_q[PH_V1];
    assign tim.w1 = ph_q[PH_W1];
    assign tim.x8 = ph_q[PH_X8];
    assign tim.y8 = ph_q[PH_Y8];
    assign tim.z1 = ph_q[PH_Z1];

endmodule

// ==== rtl/chan_sequencer.sv ====
`timescale 1ns/1ps

module chan_sequencer
    import telem_pkg::*;
(
    input  logic            sim_clk,
    input  logic            reset,
    telem_timing_if.sink    tim,
    telem_cond_if.sink      cond,
    input  logic            chan_sel,
    input  logic            trp,
    output logic [GT_W-1:0] gt
);

    logic in_s1;
    logic in_s2;
    logic in_s3;
    logic leave_ok;
    logic enabled;
    logic load;
    logic advance;
    logic [GT_W-1:0] gt_rot;

    assign in_s1 = gt[0];
    assign in_s2 = gt[1];
    assign in_s3 = gt[2];

    // one qualifier per state.
    assign leave_ok = (in_s1 & cond.codgv)
                    | (in_s2 & cond.etcr)
                    | (in_s3 & (cond.mcft2 | trp));

    assign enabled = chan_sel & cond.paav & cond.resmv;

    assign load    = tim.y8 & chan_sel & cond.dls;
    assign advance = tim.w1 & enabled & leave_ok;

    // state 1 -> 2 -> 3 -> 1.
    assign gt_rot = {gt[GT_W-2:0], gt[GT_W-1]};

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            gt <= GT_W'(1);
        end else if (load) begin
            // y8 and w1 never coincide.
            gt <= GT_W'(1);
        end else if (advance) begin
            gt <= gt_rot;
        end
    end

endmodule

// ==== rtl/trap_sync.sv ====
`timescale 1ns/1ps

module trap_sync
    import telem_pkg::*;
(
    input  logic         sim_clk,
    input  logic         reset,
    telem_timing_if.sink tim,
    input  logic         tsync,
    input  logic         gcsync,
    input  logic         icr1,
    input  logic         ocr,
    input  logic         tlm,
    output logic         trp,
    output logic         trpc,
    output logic         tcw,
    output logic         syncp
);

    logic                     tsync_meta;
    logic                     tsync_s;
    logic [SYNC_FILT_LEN-1:0] gc_hist;
    logic                     gc_filt;

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            tsync_meta <= 1'b0;
            tsync_s    <= 1'b0;
            gc_hist    <= '0;
        end else begin
            tsync_meta <= tsync;
            tsync_s    <= tsync_meta;
            gc_hist    <= {gc_hist[SYNC_FILT_LEN-2:0], gcsync};
        end
    end

    assign gc_filt = &gc_hist; // full run of high samples.

    // icr1 picks the ground sync.
    always_ff @(posedge sim_clk) begin
        if (reset) begin
            syncp <= 1'b0;
        end else begin
            syncp <= icr1 ? gc_filt : tsync_s;
        end
    end

    // trap and its clear.
    always_ff @(posedge sim_clk) begin
        if (reset) begin
            trp  <= 1'b0;
            trpc <= 1'b0;
        end else begin
            if (tim.z1 && trp) begin
                trpc <= 1'b1;
                trp  <= 1'b0;
            end else if (tim.x8 && syncp && !trpc) begin
                trp <= 1'b1;
            end
            if (tim.y8 && !syncp) begin
                trpc <= 1'b0; // sync gone.
            end
        end
    end

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            tcw <= 1'b0;
        end else if (tim.x8 && (ocr || tlm)) begin
            tcw <= 1'b0;
        end else if (tim.w1 && trp) begin
            tcw <= 1'b1;
        end
    end

endmodule

// ==== rtl/data_timing.sv ====
`timescale 1ns/1ps

module data_timing
    import telem_pkg::*;
(
    input  logic            sim_clk,
    input  logic            reset,
    telem_timing_if.sink    tim,
    input  logic            pabg1v,
    input  logic            pbg2v,
    input  logic            etcr,
    input  logic            dsd,
    input  logic            datav,
    output logic [DT_W-1:0] dt,
    output logic            din
);

    logic dt_load;
    logic dt_step;
    logic din_set;
    logic [DT_W-1:0] dt_rot;

    assign dt_load = tim.y8 & pabg1v;
    assign dt_step = tim.z1 & pbg2v & ~etcr;

    assign dt_rot = {dt[DT_W-2:0], dt[DT_W-1]};

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            dt <= DT_W'(1);
        end else if (dt_load) begin
            dt <= DT_W'(1);
        end else if (dt_step) begin
            dt <= dt_rot; // one step per frame at most.
        end
    end

    // sampled at w1, dropped at z1.
    assign din_set = tim.w1 & ((dsd & dt[0]) | (datav & dt[2]));

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            din <= 1'b0;
        end else if (tim.z1) begin
            din <= 1'b0;
        end else if (din_set) begin
            din <= 1'b1;
        end
    end

endmodule

// ==== rtl/telem_control.sv ====
`timescale 1ns/1ps

module telem_control
    import telem_pkg::*;
(
    input  logic                     sim_clk,
    input  logic                     reset,
    telem_timing_if.sink             tim,
    input  logic                     paav,
    input  logic                     resmv,
    input  logic                     codgv,
    input  logic                     etcr,
    input  logic                     mcft2,
    input  logic                     dls,
    input  logic [NUM_CHAN-1:0]      dc_sel,
    input  logic                     tsync,
    input  logic                     gcsync,
    input  logic                     icr1,
    input  logic                     ocr,
    input  logic                     tlm,
    input  logic                     pabg1v,
    input  logic                     pbg2v,
    input  logic                     dsd,
    input  logic                     datav,
    output logic [NUM_CHAN*GT_W-1:0] chan_gt,
    output logic                     trp,
    output logic                     tcw,
    output logic                     syncp,
    output logic [DT_W-1:0]          dt,
    output logic                     din
);

    logic [GT_W-1:0] gt_w [NUM_CHAN];

    telem_cond_if cond_bus ();

    // shared by all four channels.
    assign cond_bus.paav  = paav;
    assign cond_bus.resmv = resmv;
    assign cond_bus.codgv = codgv;
    assign cond_bus.etcr  = etcr;
    assign cond_bus.mcft2 = mcft2;
    assign cond_bus.dls   = dls;

    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        chan_sequencer u_seq (
            .sim_clk  (sim_clk),
            .reset    (reset),
            .tim      (tim),
            .cond     (cond_bus),
            .chan_sel (dc_sel[i]),
            .trp      (trp),
            .gt       (gt_w[i])
        );

        assign chan_gt[i*GT_W +: GT_W] = gt_w[i]; // channel 1 low.
    end

    trap_sync u_trap_sync (
        .sim_clk (sim_clk),
        .reset   (reset),
        .tim     (tim),
        .tsync   (tsync),
        .gcsync  (gcsync),
        .icr1    (icr1),
        .ocr     (ocr),
        .tlm     (tlm),
        .trp     (trp),
        .trpc    (),
        .tcw     (tcw),
        .syncp   (syncp)
    );

    data_timing u_data_timing (
        .sim_clk (sim_clk),
        .reset   (reset),
        .tim     (tim),
        .pabg1v  (pabg1v),
        .pbg2v   (pbg2v),
        .etcr    (etcr),
        .dsd     (dsd),
        .datav   (datav),
        .dt      (dt),
        .din     (din)
    );

endmodule

// ==== rtl/telem_top.sv ====
`timescale 1ns/1ps

module telem_top
    import telem_pkg::*;
(
    input  logic                     sim_clk,
    input  logic                     reset,
    input  logic                     paav,
    input  logic                     resmv,
    input  logic                     codgv,
    input  logic                     etcr,
    input  logic                     mcft2,
    input  logic                     dls,
    input  logic [NUM_CHAN-1:0]      dc_sel,
    input  logic                     tsync,
    input  logic                     gcsync,
    input  logic                     icr1,
    input  logic                     ocr,
    input  logic                     tlm,
    input  logic                     pabg1v,
    input  logic                     pbg2v,
    input  logic                     dsd,
    input  logic                     datav,
    output logic [NUM_CHAN*GT_W-1:0] chan_gt,
    output logic                     trp,
    output logic                     tcw,
    output logic                     syncp,
    output logic [DT_W-1:0]          dt,
    output logic                     din
);

    telem_timing_if tim_bus ();

    telem_pulse_gen u_pulse_gen (
        .sim_clk (sim_clk),
        .reset   (reset),
        .tim     (tim_bus)
    );

    telem_control u_control (
        .sim_clk (sim_clk),
        .reset   (reset),
        .tim     (tim_bus),
        .paav    (paav),
        .resmv   (resmv),
        .codgv   (codgv),
        .etcr    (etcr),
        .mcft2   (mcft2),
        .dls     (dls),
        .dc_sel  (dc_sel),
        .tsync   (tsync),
        .gcsync  (gcsync),
        .icr1    (icr1),
        .ocr     (ocr),
        .tlm     (tlm),
        .pabg1v  (pabg1v),
        .pbg2v   (pbg2v),
        .dsd     (dsd),
        .datav   (datav),
        .chan_gt (chan_gt),
        .trp     (trp),
        .tcw     (tcw),
        .syncp   (syncp),
        .dt      (dt),
        .din     (din)
    );

endmodule

// ==== verification/telem_tb.sv ====
`timescale 1ns/1ps

module telem_tb
    import telem_pkg::*;
;

    localparam int WAIT_LIMIT = 200;
    localparam int FRAME      = NUM_PH;
    localparam int TO_W1      = PH_W1 + 1; // stop right after the w1 edge.
    localparam int TO_X8      = PH_X8 + 1;
    localparam int SHORT_GC   = SYNC_FILT_LEN - 1;
    localparam int PRE_GC     = FRAME + 1 - SHORT_GC; // short pulse then ends on the v1 edge.

    logic                     sim_clk;
    logic                     reset;
    logic                     paav;
    logic                     resmv;
    logic                     codgv;
    logic                     etcr;
    logic                     mcft2;
    logic                     dls;
    logic [NUM_CHAN-1:0]      dc_sel;
    logic                     tsync;
    logic                     gcsync;
    logic                     icr1;
    logic                     ocr;
    logic                     tlm;
    logic                     pabg1v;
    logic                     pbg2v;
    logic                     dsd;
    logic                     datav;
    logic [NUM_CHAN*GT_W-1:0] chan_gt;
    logic                     trp;
    logic                     tcw;
    logic                     syncp;
    logic [DT_W-1:0]          dt;
    logic                     din;

    // one entry per row.
    string                    name_q[$];
    int                       ncyc_q[$];
    logic [5:0]               cond_q[$];
    logic [NUM_CHAN-1:0]      sel_q[$];
    logic [4:0]               sync_q[$];
    logic [3:0]               dat_q[$];
    logic [NUM_CHAN*GT_W-1:0] exp_gt_q[$];
    logic [2:0]               exp_fl_q[$];
    logic [DT_W-1:0]          exp_dt_q[$];
    logic                     exp_din_q[$];

    telem_top telem_top_inst (.*);

    always #20 sim_clk = ~sim_clk;

    task automatic add_row(input string name, input int ncyc, input logic [18:0] stim,
                           input logic [NUM_CHAN*GT_W-1:0] gt, input logic [6:0] res);
        name_q.push_back(name);
        ncyc_q.push_back(ncyc);
        cond_q.push_back(stim[18:13]);
        sel_q.push_back(stim[12:9]);
        sync_q.push_back(stim[8:4]);
        dat_q.push_back(stim[3:0]);
        exp_gt_q.push_back(gt);
        exp_fl_q.push_back(res[6:4]);
        exp_dt_q.push_back(res[3:1]);
        exp_din_q.push_back(res[0]);
    endtask

    task automatic drive_row(input int i);
        {paav, resmv, codgv, etcr, mcft2, dls} <= cond_q[i];
        dc_sel <= sel_q[i];
        {tsync, gcsync, icr1, ocr, tlm} <= sync_q[i];
        {pabg1v, pbg2v, dsd, datav} <= dat_q[i];
    endtask

    task automatic wait_cycles(input int n);
        int cnt;
        int guard;
        cnt   = 0;
        guard = 0;
        while (cnt < n && guard < WAIT_LIMIT) begin
            @(posedge sim_clk);
            cnt++;
            guard++;
        end
        if (cnt < n) begin
            $display("timed out while counting %0d clock cycles", n);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic check_gt(input string name, input logic [NUM_CHAN*GT_W-1:0] exp,
                            input logic [NUM_CHAN*GT_W-1:0] act);
        if (act !== exp) begin
            $display("Mismatch %s chan_gt expected %h actual %h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic check_dt(input string name, input logic [DT_W-1:0] exp,
                            input logic [DT_W-1:0] act);
        if (act !== exp) begin
            $display("Mismatch %s dt expected %b actual %b", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            $display("Mismatch %s %s expected %b actual %b", name, what, exp, act);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic check_row(input int i);
        check_gt(name_q[i], exp_gt_q[i], chan_gt);
        check_flag(name_q[i], "trp", exp_fl_q[i][2], trp);
        check_flag(name_q[i], "tcw", exp_fl_q[i][1], tcw);
        check_flag(name_q[i], "syncp", exp_fl_q[i][0], syncp);
        check_dt(name_q[i], exp_dt_q[i], dt);
        check_flag(name_q[i], "din", exp_din_q[i], din);
    endtask

    task automatic build_table();
        // stim: cond_sel_sync_dat. cond: paav resmv codgv etcr mcft2 dls.
        // sync: tsync gcsync icr1 ocr tlm. dat: pabg1v pbg2v dsd datav.
        // res: flags_dt_din, flags trp tcw syncp. gt has channel 0 low.
        add_row("reset_idle", FRAME, 19'b000000_0000_00000_0000, 12'h249, 7'b000_001_0);
        add_row("ch0_s1_to_s2", FRAME, 19'b111000_0001_00000_0000, 12'h24a, 7'b000_001_0);
        add_row("ch0_s2_no_etcr", FRAME, 19'b111000_0001_00000_0000, 12'h24a, 7'b000_001_0);
        add_row("ch0_s2_to_s3", FRAME, 19'b110100_0001_00000_0000, 12'h24c, 7'b000_001_0);
        add_row("ch0_unselected", FRAME, 19'b110010_0010_00000_0000, 12'h24c, 7'b000_001_0);
        add_row("ch0_s3_to_s1", FRAME, 19'b110010_0001_00000_0000, 12'h249, 7'b000_001_0);
        add_row("ch2_s1_to_s2", FRAME, 19'b111000_0100_00000_0000, 12'h289, 7'b000_001_0);
        add_row("ch2_dls_load", FRAME, 19'b000001_0100_00000_0000, 12'h249, 7'b000_001_0);
        add_row("ch3_no_paav", PRE_GC, 19'b011000_1000_00000_0000, 12'h249, 7'b000_001_0);
        // two high samples only, one short of setting trp at x8.
        add_row("gc_short", SHORT_GC, 19'b000000_0000_01100_0000, 12'h249, 7'b000_001_0);
        add_row("gc_short_x8", TO_X8 - 1, 19'b000000_0000_00100_0000, 12'h249, 7'b000_001_0);
        add_row("gc_short_end", FRAME - TO_X8, 19'b000000_0000_00100_0000, 12'h249, 7'b000_001_0);
        add_row("gc_full", FRAME, 19'b000000_0000_01100_0000, 12'h249, 7'b001_001_0);
        add_row("gc_trap_set", TO_X8, 19'b000000_0000_01100_0000, 12'h249, 7'b101_001_0);
        add_row("gc_trap_clr", FRAME - TO_X8, 19'b000000_0000_01100_0000, 12'h249, 7'b001_001_0);
        add_row("gc_trpc_hold", FRAME, 19'b000000_0000_01100_0000, 12'h249, 7'b001_001_0);
        add_row("gc_drop", FRAME, 19'b000000_0000_00100_0000, 12'h249, 7'b000_001_0);
        add_row("ts_sync_rise", FRAME, 19'b000000_0000_10000_0000, 12'h249, 7'b001_001_0);
        add_row("ts_trap_set", TO_X8, 19'b000000_0000_10000_0000, 12'h249, 7'b101_001_0);
        add_row("ts_trap_clr", FRAME - TO_X8, 19'b000000_0000_10000_0000, 12'h249, 7'b001_001_0);
        add_row("ts_drop", FRAME, 19'b000000_0000_00000_0000, 12'h249, 7'b000_001_0);
        // trp never spans a w1 edge, so tcw stays low.
        add_row("cmd_word_clear", FRAME, 19'b000000_0000_00011_0000, 12'h249, 7'b000_001_0);
        add_row("dt_rotate", FRAME, 19'b000000_0000_00000_0100, 12'h249, 7'b000_010_0);
        add_row("dt_etcr_hold", FRAME, 19'b000100_0000_00000_0100, 12'h249, 7'b000_010_0);
        add_row("dt_rotate2", FRAME, 19'b000000_0000_00000_0100, 12'h249, 7'b000_100_0);
        add_row("din_datav_mid", TO_W1, 19'b000000_0000_00000_0001, 12'h249, 7'b000_100_1);
        add_row("din_datav_end", FRAME - TO_W1, 19'b000000_0000_00000_1001, 12'h249, 7'b000_001_0);
        add_row("din_dsd_mid", TO_W1, 19'b000000_0000_00000_0010, 12'h249, 7'b000_001_1);
        add_row("din_dsd_end", FRAME - TO_W1, 19'b000000_0000_00000_0110, 12'h249, 7'b000_010_0);
        add_row("din_dsd_state2", TO_W1, 19'b000000_0000_00000_0010, 12'h249, 7'b000_010_0);
        add_row("dt_load_step", FRAME - TO_W1, 19'b000000_0000_00000_1100, 12'h249, 7'b000_010_0);
        add_row("dt_reload", FRAME, 19'b000000_0000_00000_1000, 12'h249, 7'b000_001_0);
    endtask

    initial begin
        int guard;
        int num_rows;
        sim_clk = 1'b0;
        reset   = 1'b1;
        {paav, resmv, codgv, etcr, mcft2, dls} = '0;
        dc_sel = '0;
        {tsync, gcsync, icr1, ocr, tlm} = '0;
        {pabg1v, pbg2v, dsd, datav} = '0;
        build_table();
        num_rows = name_q.size();

        repeat (3) @(posedge sim_clk);
        reset <= 1'b0;

        // first v1 after reset release.
        guard = 0;
        while (telem_top_inst.tim_bus.v1 !== 1'b1 && guard < WAIT_LIMIT) begin
            @(negedge sim_clk);
            guard++;
        end
        if (telem_top_inst.tim_bus.v1 !== 1'b1) begin
            $display("timed out waiting for the first frame after reset release");
            $display("ERRORS FOUND");
            $fatal(1);
        end
        wait_cycles(FRAME); // now at the start of the next frame.

        drive_row(0);
        for (int i = 0; i < num_rows; i++) begin
            wait_cycles(ncyc_q[i]);
            if (i + 1 < num_rows) begin
                drive_row(i + 1);
            end
            @(negedge sim_clk);
            check_row(i);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/telem_pkg.sv
rtl/telem_timing_if.sv
rtl/telem_cond_if.sv
rtl/telem_pulse_gen.sv
rtl/chan_sequencer.sv
rtl/trap_sync.sv
rtl/data_timing.sv
rtl/telem_control.sv
rtl/telem_top.sv
verification/telem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module telem_tb -o telem_sim

# the simulator exits non-zero on a failed check, so grep decides.
sim_out=$(./obj_dir/telem_sim 2>&1) || true
echo "$sim_out"

if grep -qx "NO ERRORS" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi
